/* src/softcore_pkg.sv */
// Softcore shared definitions
`default_nettype none

package softcore_pkg;

   // ------------------------------
   // Field and word widths
   // ------------------------------

   // Opcode field width of the command word
   localparam int OP_W = 4;
   // Address field width, shared by the program counter and the register index
   localparam int ADDR_W = 8;
   // Data field width, also the width of every register
   localparam int DATA_W = 8;
   // Full command word width
   localparam int CMD_W = OP_W + ADDR_W + DATA_W;

   // Number of words in the program store
   localparam int NUM_CMDS = 256;

   // Number of addressable register slots
   localparam int NUM_REGS = 5;

   // Clocks per wait tick
   localparam int TICK_CYCLES = 10;
   // Wide enough for 255 ticks of TICK_CYCLES clocks plus one
   localparam int TIMER_W = 12;

   typedef logic [DATA_W-1:0] byte_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [CMD_W-1:0] cmd_t;
   typedef logic [TIMER_W-1:0] timer_t;

   // ------------------------------
   // Register map
   // ------------------------------

   // Slot 0 is the accumulator and also selects the immediate operand
   localparam addr_t REG_ACC = 8'd0;
   localparam addr_t REG_LED_LO = 8'd1;
   localparam addr_t REG_LED_HI = 8'd2;
   // The DIP slots are read only
   localparam addr_t REG_DIP_LO = 8'd3;
   localparam addr_t REG_DIP_HI = 8'd4;

   // ------------------------------
   // Instruction set
   // ------------------------------

   // Encodings are fixed so that programs can be built outside the design
   typedef enum logic [OP_W-1:0] {
      OP_WAIT           = 4'h0,
      OP_WAIT_ON_BUTTON = 4'h1,
      OP_STORE_DIRECT   = 4'h2,
      OP_STORE          = 4'h3,
      OP_LOAD           = 4'h4,
      OP_ADD            = 4'h5,
      OP_AND            = 4'h6,
      OP_OR             = 4'h7,
      OP_XOR            = 4'h8,
      OP_NOT            = 4'h9,
      OP_JUMP           = 4'hA,
      OP_JUMP_GT        = 4'hB,
      OP_JUMP_EQ        = 4'hC,
      OP_JUMP_LT        = 4'hD,
      OP_TERM           = 4'hE
   } opcode_t;

   // Processor FSM states
   typedef enum logic [2:0] {
      ST_INIT,
      ST_FETCH,
      ST_WAIT,
      ST_WAIT_BUTTON,
      ST_EXECUTE,
      ST_INCREMENT,
      ST_TERM
   } proc_state_t;

endpackage

`default_nettype wire

/* src/program_mem.sv */
// Program command store
`default_nettype none
`timescale 1ns/1ps

module program_mem import softcore_pkg::*; (
   input wire logic clk_in,
   input wire logic load_en,
   input wire addr_t load_addr,
   input wire cmd_t load_cmd,
   input wire addr_t pc,
   output cmd_t cmd
);

   // One command word per program address
   cmd_t mem [NUM_CMDS];

   // ------------------------------
   // Load port
   // ------------------------------

   // The program is written one word per clock from outside
   // The store holds no reset, its contents only come from the load port
   always_ff @(posedge clk_in) begin
      if (load_en) begin
         mem[load_addr] <= load_cmd;
      end
   end

   // ------------------------------
   // Fetch port
   // ------------------------------

   // Combinational read so the command is visible in the same cycle as pc
   // All units decode from this one word
   assign cmd = mem[pc];

   // ------------------------------
   // Checks
   // ------------------------------

   // Loading must only happen while the processor sits in INIT
   // In INIT the counter is held at zero, so a write edge never moves pc
   a_load_in_init : assert property (
      @(posedge clk_in) load_en |=> $stable(pc)
   ) else $error("Program loaded while the processor was running");

endmodule

`default_nettype wire

/* src/sequencer.sv */
// Processor state machine
`default_nettype none
`timescale 1ns/1ps

module sequencer import softcore_pkg::*; (
   input wire logic clk_in,
   input wire logic nrst_in,
   input wire logic enable,
   input wire logic button,
   input wire logic wait_done,
   input wire cmd_t cmd,
   input wire byte_t acc,
   output addr_t pc,
   output logic exec_en,
   output logic wait_active,
   output logic term
);

   proc_state_t state;
   opcode_t opcode;
   addr_t cmd_addr;
   byte_t cmd_data;
   logic jump_taken;

   // Split the command word into its fields
   assign opcode = opcode_t'(cmd[CMD_W-1 -: OP_W]);
   assign cmd_addr = cmd[ADDR_W+DATA_W-1 -: ADDR_W];
   assign cmd_data = cmd[DATA_W-1:0];

   // ------------------------------
   // State transitions
   // ------------------------------

   // This block only decides where the FSM goes next
   // What each state does is spread over the other units
   always_ff @(posedge clk_in) begin
      if (!nrst_in) begin
         state <= ST_INIT;
      end else begin
         case (state)
            // Hold until the processor is enabled
            ST_INIT: if (enable) state <= ST_FETCH;
            ST_FETCH: begin
               // The opcode is only used here to choose the next state
               case (opcode)
                  OP_WAIT: state <= ST_WAIT;
                  OP_WAIT_ON_BUTTON: state <= ST_WAIT_BUTTON;
                  OP_STORE_DIRECT,
                  OP_STORE,
                  OP_LOAD,
                  OP_ADD,
                  OP_AND,
                  OP_OR,
                  OP_XOR,
                  OP_NOT: state <= ST_EXECUTE;
                  // Jumps need no execute cycle, the counter resolves them
                  OP_JUMP,
                  OP_JUMP_GT,
                  OP_JUMP_EQ,
                  OP_JUMP_LT: state <= ST_INCREMENT;
                  // An unknown opcode halts the program like TERM does
                  default: state <= ST_TERM;
               endcase
            end
            // The timer was cleared on entry and counts while we sit here
            ST_WAIT: if (wait_done) state <= ST_INCREMENT;
            ST_WAIT_BUTTON: if (button) state <= ST_INCREMENT;
            // Every operation completes in a single cycle
            ST_EXECUTE: state <= ST_INCREMENT;
            ST_INCREMENT: state <= ST_FETCH;
            // Dropping enable restarts from INIT
            ST_TERM: if (!enable) state <= ST_INIT;
            default: state <= ST_INIT;
         endcase
      end
   end

   // ------------------------------
   // Program counter
   // ------------------------------

   // Branch conditions compare the data field against the accumulator
   always_comb begin
      case (opcode)
         OP_JUMP: jump_taken = 1'b1;
         OP_JUMP_GT: jump_taken = (cmd_data > acc);
         OP_JUMP_EQ: jump_taken = (cmd_data == acc);
         OP_JUMP_LT: jump_taken = (cmd_data < acc);
         default: jump_taken = 1'b0;
      endcase
   end

   // The counter only moves in INCREMENT, and is cleared in INIT so that
   // a restart begins at address 0
   always_ff @(posedge clk_in) begin
      if (!nrst_in) begin
         pc <= '0;
      end else if (state == ST_INIT) begin
         pc <= '0;
      end else if (state == ST_INCREMENT) begin
         // The jump target loads directly since both share ADDR_W
         pc <= jump_taken ? cmd_addr : pc + 1'b1;
      end
   end

   // ------------------------------
   // State decodes
   // ------------------------------

   assign exec_en = (state == ST_EXECUTE);
   assign wait_active = (state == ST_WAIT);
   assign term = (state == ST_TERM);

   a_state_legal : assert property (
      @(posedge clk_in) disable iff (!nrst_in)
      state inside {ST_INIT, ST_FETCH, ST_WAIT, ST_WAIT_BUTTON,
                    ST_EXECUTE, ST_INCREMENT, ST_TERM}
   ) else $error("Sequencer reached an illegal state");

   a_exec_not_term : assert property (
      @(posedge clk_in) disable iff (!nrst_in) !(exec_en && term)
   ) else $error("Execute strobe raised while terminated");

endmodule

`default_nettype wire

/* src/register_file.sv */
// Accumulator and I/O registers
`default_nettype none
`timescale 1ns/1ps

module register_file import softcore_pkg::*; (
   input wire logic clk_in,
   input wire logic exec_en,
   input wire logic acc_write,
   input wire cmd_t cmd,
   input wire byte_t alu_result,
   input wire logic [15:0] dip,
   output byte_t acc,
   output byte_t operand,
   output logic [15:0] leds
);

   opcode_t opcode;
   addr_t cmd_addr;
   byte_t cmd_data;
   byte_t led_lo;
   byte_t led_hi;
   logic store_en;
   byte_t store_val;

   assign opcode = opcode_t'(cmd[CMD_W-1 -: OP_W]);
   assign cmd_addr = cmd[ADDR_W+DATA_W-1 -: ADDR_W];
   assign cmd_data = cmd[DATA_W-1:0];

   // ------------------------------
   // Accumulator
   // ------------------------------

   // Data registers carry no reset
   // The ALU decides whether its result belongs in the accumulator
   always_ff @(posedge clk_in) begin
      if (exec_en && acc_write) begin
         acc <= alu_result;
      end
   end

   // ------------------------------
   // LED registers
   // ------------------------------

   // STORE_DIRECT writes the immediate, STORE writes the accumulator
   assign store_en = exec_en && (opcode == OP_STORE_DIRECT || opcode == OP_STORE);
   assign store_val = (opcode == OP_STORE_DIRECT) ? cmd_data : acc;

   // Stores to slot 0 or to the DIP slots fall through and are ignored
   always_ff @(posedge clk_in) begin
      if (store_en) begin
         case (cmd_addr)
            REG_LED_LO: led_lo <= store_val;
            REG_LED_HI: led_hi <= store_val;
            default: ;
         endcase
      end
   end

   assign leds = {led_hi, led_lo};

   // ------------------------------
   // Operand select
   // ------------------------------

   // Address 0 selects the immediate data field rather than the accumulator
   // Slots beyond NUM_REGS-1 read as zero
   always_comb begin
      case (cmd_addr)
         REG_ACC: operand = cmd_data;
         REG_LED_LO: operand = led_lo;
         REG_LED_HI: operand = led_hi;
         REG_DIP_LO: operand = dip[7:0];
         REG_DIP_HI: operand = dip[15:8];
         default: operand = '0;
      endcase
   end

endmodule

`default_nettype wire

/* src/alu.sv */
// Arithmetic logic unit
`default_nettype none
`timescale 1ns/1ps

module alu import softcore_pkg::*; (
   input wire cmd_t cmd,
   input wire byte_t acc,
   input wire byte_t operand,
   output byte_t alu_result,
   output logic acc_write
);

   opcode_t opcode;

   assign opcode = opcode_t'(cmd[CMD_W-1 -: OP_W]);

   // ------------------------------
   // Result select
   // ------------------------------

   // Purely combinational, the register file latches the result in EXECUTE
   // The adder wraps modulo 256 since the carry is dropped
   always_comb begin
      alu_result = acc;
      acc_write = 1'b1;
      case (opcode)
         OP_LOAD: alu_result = operand;
         OP_ADD: alu_result = acc + operand;
         OP_AND: alu_result = acc & operand;
         OP_OR: alu_result = acc | operand;
         OP_XOR: alu_result = acc ^ operand;
         // NOT ignores the operand entirely
         OP_NOT: alu_result = ~acc;
         default: begin
            // Everything else leaves the accumulator alone
            acc_write = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/wait_timer.sv */
// Wait tick timer
`default_nettype none
`timescale 1ns/1ps

module wait_timer import softcore_pkg::*; (
   input wire logic clk_in,
   input wire logic wait_active,
   input wire cmd_t cmd,
   output logic wait_done
);

   timer_t count;
   timer_t limit;

   // Requested ticks converted into clocks
   assign limit = timer_t'(cmd[DATA_W-1:0]) * timer_t'(TICK_CYCLES);

   // ------------------------------
   // Counter
   // ------------------------------

   // Counts every clock in WAIT and returns to zero otherwise
   // The sequencer sits in INIT after reset, so the count clears itself
   always_ff @(posedge clk_in) begin
      if (wait_active) begin
         count <= count + 1'b1;
      end else begin
         count <= '0;
      end
   end

   // Starting from zero, done arrives on the (limit+1)th WAIT cycle
   assign wait_done = (count >= limit);

   // The sequencer must leave WAIT as soon as done is seen
   a_count_bound : assert property (
      @(posedge clk_in) wait_active |-> (count <= limit + 1'b1)
   ) else $error("Wait timer ran past its limit");

endmodule

`default_nettype wire

/* src/softcore_top.sv */
// Softcore processor top level
`default_nettype none
`timescale 1ns/1ps

module softcore_top import softcore_pkg::*; (
   input wire logic clk_in,
   input wire logic nrst_in,
   input wire logic enable,
   input wire logic button,
   input wire logic [15:0] dip,
   input wire logic load_en,
   input wire addr_t load_addr,
   input wire cmd_t load_cmd,
   output logic [15:0] leds,
   output logic term
);

   // ------------------------------
   // Internal nets
   // ------------------------------

   cmd_t cmd;
   addr_t pc;
   logic exec_en;
   logic wait_active;
   logic wait_done;
   byte_t acc;
   byte_t operand;
   byte_t alu_result;
   logic acc_write;

   // Command store, read at the current pc
   program_mem u_program_mem (
      .clk_in(clk_in),
      .load_en(load_en),
      .load_addr(load_addr),
      .load_cmd(load_cmd),
      .pc(pc),
      .cmd(cmd)
   );

   // Steps every other unit in lockstep
   sequencer u_sequencer (
      .clk_in(clk_in),
      .nrst_in(nrst_in),
      .enable(enable),
      .button(button),
      .wait_done(wait_done),
      .cmd(cmd),
      .acc(acc),
      .pc(pc),
      .exec_en(exec_en),
      .wait_active(wait_active),
      .term(term)
   );

   register_file u_register_file (
      .clk_in(clk_in),
      .exec_en(exec_en),
      .acc_write(acc_write),
      .cmd(cmd),
      .alu_result(alu_result),
      .dip(dip),
      .acc(acc),
      .operand(operand),
      .leds(leds)
   );

   alu u_alu (
      .cmd(cmd),
      .acc(acc),
      .operand(operand),
      .alu_result(alu_result),
      .acc_write(acc_write)
   );

   wait_timer u_wait_timer (
      .clk_in(clk_in),
      .wait_active(wait_active),
      .cmd(cmd),
      .wait_done(wait_done)
   );

endmodule

`default_nettype wire

/* tb/tb_softcore.sv */
// Softcore testbench
`default_nettype none
`timescale 1ns/1ps

module tb_softcore import softcore_pkg::*; ();

   logic clk_in = 1'b0;
   logic nrst_in;
   logic enable;
   logic button;
   logic [15:0] dip;
   logic load_en;
   addr_t load_addr;
   cmd_t load_cmd;
   logic [15:0] leds;
   logic term;

   // Program image shared by the load port and the reference model
   cmd_t prog [NUM_CMDS];
   int prog_len;
   // Architectural state of the model, carried across tests like the DUT's registers
   byte_t model_acc;
   logic [15:0] model_leds;
   int pass_count = 0;
   int fail_count = 0;
   int seed = 20;
   // Cycle allowance grows as each test is set up
   int budget = 100;
   int elapsed;

   always #50 clk_in = ~clk_in;

   softcore_top uut (
      .clk_in(clk_in),
      .nrst_in(nrst_in),
      .enable(enable),
      .button(button),
      .dip(dip),
      .load_en(load_en),
      .load_addr(load_addr),
      .load_cmd(load_cmd),
      .leds(leds),
      .term(term)
   );

   // ------------------------------
   // Reference model
   // ------------------------------

   // Address 0 picks the immediate, slots 1 to 4 are LEDs and DIPs, the rest read zero
   function automatic byte_t model_operand(input addr_t a, input byte_t d,
                                           input logic [15:0] dip_v);
      case (a)
         REG_ACC: return d;
         REG_LED_LO: return model_leds[7:0];
         REG_LED_HI: return model_leds[15:8];
         REG_DIP_LO: return dip_v[7:0];
         REG_DIP_HI: return dip_v[15:8];
         default: return 8'h00;
      endcase
   endfunction

   // Only the two LED slots take stores
   function automatic void write_led(input addr_t a, input byte_t v);
      if (a == REG_LED_LO) begin
         model_leds[7:0] = v;
      end else if (a == REG_LED_HI) begin
         model_leds[15:8] = v;
      end
   endfunction

   // Interprets prog and counts cycles from leaving INIT to raising term
   function automatic void run_model(input logic [15:0] dip_v, output logic [15:0] exp_leds,
                                     output int exp_cycles);
      addr_t pc_m;
      addr_t pc_next;
      opcode_t op;
      addr_t a;
      byte_t d;
      byte_t opnd;
      int cyc;
      int steps;
      bit done;
      pc_m = '0;
      exp_cycles = 0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < 1000) begin
         op = opcode_t'(prog[pc_m][CMD_W-1 -: OP_W]);
         a = prog[pc_m][ADDR_W+DATA_W-1 -: ADDR_W];
         d = prog[pc_m][DATA_W-1:0];
         opnd = model_operand(a, d, dip_v);
         pc_next = pc_m + 8'd1;
         // FETCH, EXECUTE and INCREMENT
         cyc = 3;
         case (op)
            // FETCH, limit+1 cycles of WAIT, then INCREMENT
            OP_WAIT: cyc = int'(d) * TICK_CYCLES + 3;
            // The button is taken as already high here
            OP_WAIT_ON_BUTTON: cyc = 3;
            OP_STORE_DIRECT: write_led(a, d);
            OP_STORE: write_led(a, model_acc);
            OP_LOAD: model_acc = opnd;
            OP_ADD: model_acc = model_acc + opnd;
            OP_AND: model_acc = model_acc & opnd;
            OP_OR: model_acc = model_acc | opnd;
            OP_XOR: model_acc = model_acc ^ opnd;
            OP_NOT: model_acc = ~model_acc;
            // Jumps skip EXECUTE
            OP_JUMP: begin
               cyc = 2;
               pc_next = a;
            end
            OP_JUMP_GT: begin
               cyc = 2;
               if (d > model_acc) pc_next = a;
            end
            OP_JUMP_EQ: begin
               cyc = 2;
               if (d == model_acc) pc_next = a;
            end
            OP_JUMP_LT: begin
               cyc = 2;
               if (d < model_acc) pc_next = a;
            end
            // TERM and unknown opcodes halt after their FETCH cycle
            default: begin
               cyc = 1;
               done = 1'b1;
            end
         endcase
         exp_cycles += cyc;
         pc_m = pc_next;
         steps++;
      end
      exp_leds = model_leds;
   endfunction

   // ------------------------------
   // Program handling
   // ------------------------------

   task automatic append_cmd(input opcode_t op, input addr_t a, input byte_t d);
      prog[prog_len] = {op, a, d};
      prog_len++;
   endtask

   // One word per clock through the load port, only while the DUT sits in INIT
   task automatic load_program();
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clk_in);
         load_en <= 1'b1;
         load_addr <= addr_t'(i);
         load_cmd <= prog[i];
      end
      @(posedge clk_in);
      load_en <= 1'b0;
   endtask

   // Returns once the edge that leaves INIT has passed
   task automatic start_program();
      @(posedge clk_in);
      enable <= 1'b1;
      @(posedge clk_in);
   endtask

   // Counts cycles until term, sampling on the falling edge
   task automatic wait_term(output int cycles);
      cycles = 0;
      @(negedge clk_in);
      while (!term) begin
         cycles++;
         @(negedge clk_in);
      end
   endtask

   // Back to INIT, with time for pc to clear before the next load
   task automatic stop_program();
      @(posedge clk_in);
      enable <= 1'b0;
      repeat (3) @(posedge clk_in);
   endtask

   task automatic pulse_button();
      @(posedge clk_in);
      button <= 1'b1;
      @(posedge clk_in);
      button <= 1'b0;
   endtask

   // ------------------------------
   // Comparisons
   // ------------------------------

   task automatic check_leds(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
      if (act_v !== exp_v) begin
         $display("Mismatch in %s: leds expected %h, actual %h", name, exp_v, act_v);
         fail_count++;
      end else begin
         $display("ok %s: leds %h", name, act_v);
         pass_count++;
      end
   endtask

   task automatic check_cycles(input string name, input int exp_v, input int act_v);
      if (act_v != exp_v) begin
         $display("Mismatch in %s: cycles expected %0d, actual %0d", name, exp_v, act_v);
         fail_count++;
      end else begin
         $display("ok %s: %0d cycles", name, act_v);
         pass_count++;
      end
   endtask

   task automatic check_term(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         $display("Mismatch in %s: term expected %b, actual %b", name, exp_v, act_v);
         fail_count++;
      end else begin
         $display("ok %s: term %b", name, act_v);
         pass_count++;
      end
   endtask

   // Loads prog, runs it to TERM and compares leds and timing with the model
   task automatic run_checked(input string name, input logic [15:0] dip_v);
      logic [15:0] exp_leds;
      int exp_cycles;
      int act_cycles;
      @(posedge clk_in);
      dip <= dip_v;
      run_model(dip_v, exp_leds, exp_cycles);
      budget += exp_cycles + prog_len + 20;
      load_program();
      start_program();
      wait_term(act_cycles);
      check_leds(name, exp_leds, leds);
      check_cycles(name, exp_cycles, act_cycles);
      stop_program();
   endtask

   // ------------------------------
   // Watchdog
   // ------------------------------

   initial begin
      elapsed = 0;
      while (elapsed <= budget) begin
         @(posedge clk_in);
         elapsed++;
      end
      $display("Timeout: the DUT did not finish within %0d cycles", budget);
      $display("Result: FAILED");
      $finish;
   end

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      opcode_t alu_ops [5];
      opcode_t jump_ops [3];
      byte_t jump_data [3];
      logic [15:0] dip_v;
      logic [15:0] exp_leds;
      int exp_cycles;
      int act_cycles;
      byte_t imm;
      alu_ops = '{OP_ADD, OP_AND, OP_OR, OP_XOR, OP_NOT};
      jump_ops = '{OP_JUMP_GT, OP_JUMP_EQ, OP_JUMP_LT};
      // Below, equal to and above the accumulator value of 8'h40
      jump_data = '{8'h20, 8'h40, 8'h60};
      nrst_in = 1'b0;
      enable = 1'b0;
      button = 1'b0;
      dip = '0;
      load_en = 1'b0;
      load_addr = '0;
      load_cmd = '0;
      repeat (2) @(posedge clk_in);
      nrst_in <= 1'b1;
      @(negedge clk_in);
      check_term("after reset", 1'b0, term);

      // Each ALU opcode against the DIP bytes, from a DIP load and from an immediate
      foreach (alu_ops[i]) begin
         dip_v = 16'($random(seed));
         imm = 8'($random(seed));
         prog_len = 0;
         append_cmd(OP_LOAD, REG_DIP_LO, 8'h00);
         append_cmd(alu_ops[i], REG_DIP_HI, 8'h00);
         append_cmd(OP_STORE, REG_LED_LO, 8'h00);
         append_cmd(OP_LOAD, REG_ACC, imm);
         append_cmd(alu_ops[i], REG_DIP_LO, 8'h00);
         append_cmd(OP_STORE, REG_LED_HI, 8'h00);
         append_cmd(OP_TERM, '0, 8'h00);
         run_checked($sformatf("alu %s", alu_ops[i].name()), dip_v);
      end

      prog_len = 0;
      append_cmd(OP_STORE_DIRECT, REG_LED_LO, 8'h3C);
      append_cmd(OP_STORE_DIRECT, REG_LED_HI, 8'hA5);
      append_cmd(OP_TERM, '0, 8'h00);
      run_checked("direct stores", dip);

      // A DIP slot is read only, so leds must hold
      prog_len = 0;
      append_cmd(OP_STORE_DIRECT, REG_DIP_LO, 8'hFF);
      append_cmd(OP_TERM, '0, 8'h00);
      run_checked("store to slot 3", dip);

      // Unconditional jump over a marker, then one conditional jump per run
      foreach (jump_ops[j]) begin
         foreach (jump_data[k]) begin
            prog_len = 0;
            append_cmd(OP_STORE_DIRECT, REG_LED_HI, 8'h00);
            append_cmd(OP_LOAD, REG_ACC, 8'h40);
            append_cmd(OP_JUMP, 8'd4, 8'h00);
            append_cmd(OP_STORE_DIRECT, REG_LED_HI, 8'hEE);
            append_cmd(jump_ops[j], 8'd7, jump_data[k]);
            append_cmd(OP_STORE_DIRECT, REG_LED_LO, 8'h0F);
            append_cmd(OP_TERM, '0, 8'h00);
            append_cmd(OP_STORE_DIRECT, REG_LED_LO, 8'hF0);
            append_cmd(OP_TERM, '0, 8'h00);
            run_checked($sformatf("%s data %h", jump_ops[j].name(), jump_data[k]), dip);
         end
      end

      prog_len = 0;
      append_cmd(OP_STORE_DIRECT, REG_LED_LO, 8'h77);
      append_cmd(OP_WAIT, '0, 8'd3);
      append_cmd(OP_TERM, '0, 8'h00);
      run_checked("wait 3 ticks", dip);

      // Address 0 clears the high LED byte again on every pass
      // While the button is low both passes must show only the low byte
      prog_len = 0;
      append_cmd(OP_STORE_DIRECT, REG_LED_HI, 8'h00);
      append_cmd(OP_STORE_DIRECT, REG_LED_LO, 8'h5A);
      append_cmd(OP_WAIT_ON_BUTTON, '0, 8'h00);
      append_cmd(OP_STORE_DIRECT, REG_LED_HI, 8'hC3);
      append_cmd(OP_TERM, '0, 8'h00);
      run_model(dip, exp_leds, exp_cycles);
      budget += prog_len + 200;
      load_program();
      for (int r = 0; r < 2; r++) begin
         start_program();
         repeat (30) @(negedge clk_in);
         check_term($sformatf("button low, run %0d", r), 1'b0, term);
         check_leds($sformatf("before button, run %0d", r), 16'h005A, leds);
         pulse_button();
         wait_term(act_cycles);
         check_leds($sformatf("button pulsed, run %0d", r), exp_leds, leds);
         stop_program();
      end

      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
src/softcore_pkg.sv
src/program_mem.sv
src/sequencer.sv
src/register_file.sv
src/alu.sv
src/wait_timer.sv
src/softcore_top.sv
tb/tb_softcore.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_softcore -o sim_softcore

output="$(./obj_dir/sim_softcore)"
echo "$output"

if grep -q "^Result: PASSED$" <<< "$output"; then
   exit 0
else
   exit 1
fi
